// File: design/ex_params.svh
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// register file and datapath
`define EX_DATA_WIDTH     32
`define EX_REG_COUNT      8
`define EX_REG_ADDR_WIDTH 3

// micro-instruction layout
`define EX_INSTR_WIDTH    16
`define EX_OPCODE_WIDTH   4
`define EX_IMM_WIDTH      6

`endif

// File: design/flags_pkg.sv
`default_nettype none

`include "ex_params.svh"

package flags_pkg;

  typedef logic [31:0] eflags_t;

  localparam int unsigned CF_BIT = 0;
  localparam int unsigned ZF_BIT = 6;
  localparam int unsigned SF_BIT = 7;
  localparam int unsigned OF_BIT = 11;

  // zero and sign from the result, all else clear
  function automatic eflags_t result_flags(input logic [`EX_DATA_WIDTH-1:0] res);
    eflags_t f;
    f = '0;
    f[ZF_BIT] = (res == '0);
    f[SF_BIT] = res[`EX_DATA_WIDTH-1];
    return f;
  endfunction

  function automatic eflags_t add_flags(input logic [`EX_DATA_WIDTH-1:0] a,
                                        input logic [`EX_DATA_WIDTH-1:0] b);
    logic [`EX_DATA_WIDTH:0] sum;
    eflags_t f;
    sum = {1'b0, a} + {1'b0, b};
    f = result_flags(sum[`EX_DATA_WIDTH-1:0]);
    f[CF_BIT] = sum[`EX_DATA_WIDTH];
    f[OF_BIT] = (a[`EX_DATA_WIDTH-1] == b[`EX_DATA_WIDTH-1]) &&
                (sum[`EX_DATA_WIDTH-1] != a[`EX_DATA_WIDTH-1]);
    return f;
  endfunction

  // cf is the borrow, as on x86
  function automatic eflags_t sub_flags(input logic [`EX_DATA_WIDTH-1:0] a,
                                        input logic [`EX_DATA_WIDTH-1:0] b);
    logic [`EX_DATA_WIDTH:0] diff;
    eflags_t f;
    diff = {1'b0, a} - {1'b0, b};
    f = result_flags(diff[`EX_DATA_WIDTH-1:0]);
    f[CF_BIT] = diff[`EX_DATA_WIDTH];
    f[OF_BIT] = (a[`EX_DATA_WIDTH-1] != b[`EX_DATA_WIDTH-1]) &&
                (diff[`EX_DATA_WIDTH-1] != a[`EX_DATA_WIDTH-1]);
    return f;
  endfunction

  function automatic eflags_t logic_flags(input logic [`EX_DATA_WIDTH-1:0] res);
    return result_flags(res);
  endfunction

  function automatic eflags_t shift_flags(input logic [`EX_DATA_WIDTH-1:0] res,
                                          input logic last_out);
    eflags_t f;
    f = result_flags(res);
    f[CF_BIT] = last_out;
    return f;
  endfunction

endpackage

`default_nettype wire

// File: design/uop_pkg.sv
`default_nettype none

`include "ex_params.svh"

package uop_pkg;

  typedef enum logic [`EX_OPCODE_WIDTH-1:0] {
    OP_LDI     = 0,
    OP_MOV     = 1,
    OP_ADD     = 2,
    OP_SUB     = 3,
    OP_AND     = 4,
    OP_OR      = 5,
    OP_XOR     = 6,
    OP_CMP     = 7,
    OP_SHL     = 8,
    OP_SHR     = 9,
    OP_XCHG    = 10,
    OP_CMPXCHG = 11
  } opcode_e;

  // codes above cmpxchg are reserved
  function automatic logic legal_opcode(input logic [`EX_OPCODE_WIDTH-1:0] op);
    return op <= OP_CMPXCHG;
  endfunction

  // decode to execute; acc is reg0 for cmpxchg
  typedef struct packed {
    opcode_e                       opcode;
    logic [`EX_REG_ADDR_WIDTH-1:0] dst;
    logic [`EX_REG_ADDR_WIDTH-1:0] src;
    logic [`EX_DATA_WIDTH-1:0]     a;
    logic [`EX_DATA_WIDTH-1:0]     b;
    logic [`EX_DATA_WIDTH-1:0]     acc;
  } ex_payload_t;

  // execute to result
  typedef struct packed {
    logic [`EX_DATA_WIDTH-1:0]     result_a;
    logic [`EX_DATA_WIDTH-1:0]     result_b;
    logic [`EX_REG_ADDR_WIDTH-1:0] dest_a;
    logic [`EX_REG_ADDR_WIDTH-1:0] dest_b;
    logic                          ld_a;
    logic                          ld_b;
    logic                          ld_flags;
    flags_pkg::eflags_t            flags;
  } wb_payload_t;

endpackage

`default_nettype wire

// File: design/stage_if.sv
`timescale 1ns/10ps
`default_nettype none

interface stage_if #(
  parameter type payload_t = logic
);

  // one-cycle strobe, payload only meaningful with it
  logic     valid;
  payload_t payload;

  modport producer (
    output valid,
    output payload
  );

  modport consumer (
    input valid,
    input payload
  );

endinterface

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_params.svh"

module reg_file (
  input  logic                          CLK,
  input  logic                          rst,
  input  logic [`EX_REG_ADDR_WIDTH-1:0] rd_addr_a,
  input  logic [`EX_REG_ADDR_WIDTH-1:0] rd_addr_b,
  output logic [`EX_DATA_WIDTH-1:0]     rd_data_a,
  output logic [`EX_DATA_WIDTH-1:0]     rd_data_b,
  output logic [`EX_DATA_WIDTH-1:0]     rd_data_acc,
  input  logic                          we_a,
  input  logic [`EX_REG_ADDR_WIDTH-1:0] wr_addr_a,
  input  logic [`EX_DATA_WIDTH-1:0]     wr_data_a,
  input  logic                          we_b,
  input  logic [`EX_REG_ADDR_WIDTH-1:0] wr_addr_b,
  input  logic [`EX_DATA_WIDTH-1:0]     wr_data_b
);

  logic [`EX_DATA_WIDTH-1:0] regs [`EX_REG_COUNT];

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < `EX_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (we_a) begin
        regs[wr_addr_a] <= wr_data_a;
      end
      // port b last so it wins on the same index
      if (we_b) begin
        regs[wr_addr_b] <= wr_data_b;
      end
    end
  end

  // reads see the old value during a write
  assign rd_data_a   = regs[rd_addr_a];
  assign rd_data_b   = regs[rd_addr_b];
  assign rd_data_acc = regs[0];

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_params.svh"

module decode_stage (
  input  logic                          CLK,
  input  logic                          rst,
  input  logic                          instr_valid,
  input  logic [`EX_INSTR_WIDTH-1:0]    instr,
  output logic [`EX_REG_ADDR_WIDTH-1:0] rd_addr_a,
  output logic [`EX_REG_ADDR_WIDTH-1:0] rd_addr_b,
  input  logic [`EX_DATA_WIDTH-1:0]     rd_data_a,
  input  logic [`EX_DATA_WIDTH-1:0]     rd_data_b,
  input  logic [`EX_DATA_WIDTH-1:0]     rd_data_acc,
  stage_if.producer                     ex
);

  localparam int SRC_LSB = `EX_IMM_WIDTH;
  localparam int DST_LSB = `EX_IMM_WIDTH + `EX_REG_ADDR_WIDTH;

  logic [`EX_OPCODE_WIDTH-1:0]   opcode_bits;
  logic [`EX_REG_ADDR_WIDTH-1:0] dst;
  logic [`EX_REG_ADDR_WIDTH-1:0] src;
  logic [`EX_IMM_WIDTH-1:0]      imm;
  logic                          legal;
  uop_pkg::ex_payload_t          ex_next;

  // field split
  assign opcode_bits = instr[`EX_INSTR_WIDTH-1 -: `EX_OPCODE_WIDTH];
  assign dst         = instr[DST_LSB +: `EX_REG_ADDR_WIDTH];
  assign src         = instr[SRC_LSB +: `EX_REG_ADDR_WIDTH];
  assign imm         = instr[`EX_IMM_WIDTH-1:0];
  assign legal       = uop_pkg::legal_opcode(opcode_bits);

  assign rd_addr_a = dst;
  assign rd_addr_b = src;

  always_comb begin
    ex_next.opcode = uop_pkg::opcode_e'(opcode_bits);
    ex_next.dst    = dst;
    ex_next.src    = src;
    // ldi takes the zero-extended immediate in place of dst
    if (ex_next.opcode == uop_pkg::OP_LDI) begin
      ex_next.a = {{(`EX_DATA_WIDTH - `EX_IMM_WIDTH){1'b0}}, imm};
    end else begin
      ex_next.a = rd_data_a;
    end
    ex_next.b   = rd_data_b;
    ex_next.acc = rd_data_acc;
  end

  // illegal codes die here
  always_ff @(posedge CLK) begin
    if (rst) begin
      ex.valid <= 1'b0;
    end else begin
      ex.valid <= instr_valid && legal;
    end
  end

  always_ff @(posedge CLK) begin
    if (instr_valid) begin
      ex.payload <= ex_next;
    end
  end

  a_ex_legal: assert property (@(posedge CLK) disable iff (rst)
    ex.valid |-> uop_pkg::legal_opcode(ex.payload.opcode));

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_params.svh"

module execute_stage (
  input  logic       CLK,
  input  logic       rst,
  stage_if.consumer  ex,
  stage_if.producer  wb
);

  localparam int SHAMT_WIDTH = $clog2(`EX_DATA_WIDTH);

  uop_pkg::ex_payload_t      uop;
  uop_pkg::wb_payload_t      wb_next;
  logic                      is_cmpxchg;
  logic [`EX_DATA_WIDTH-1:0] lhs;
  logic [`EX_DATA_WIDTH-1:0] rhs;
  logic [`EX_DATA_WIDTH-1:0] alu_result;
  flags_pkg::eflags_t        alu_flags;
  logic [SHAMT_WIDTH-1:0]    shamt;
  logic [`EX_DATA_WIDTH:0]   shl_ext;
  logic [`EX_DATA_WIDTH:0]   shr_ext;
  logic [`EX_DATA_WIDTH-1:0] shift_result;
  flags_pkg::eflags_t        sh_flags;
  logic                      cmp_equal;

  assign uop        = ex.payload;
  assign is_cmpxchg = (uop.opcode == uop_pkg::OP_CMPXCHG);

  // cmpxchg compares reg0 against dst
  assign lhs = is_cmpxchg ? uop.acc : uop.a;
  assign rhs = is_cmpxchg ? uop.a : uop.b;

  always_comb begin
    case (uop.opcode)
      uop_pkg::OP_ADD: begin
        alu_result = lhs + rhs;
        alu_flags  = flags_pkg::add_flags(lhs, rhs);
      end
      uop_pkg::OP_AND: begin
        alu_result = lhs & rhs;
        alu_flags  = flags_pkg::logic_flags(alu_result);
      end
      uop_pkg::OP_OR: begin
        alu_result = lhs | rhs;
        alu_flags  = flags_pkg::logic_flags(alu_result);
      end
      uop_pkg::OP_XOR: begin
        alu_result = lhs ^ rhs;
        alu_flags  = flags_pkg::logic_flags(alu_result);
      end
      // sub, cmp and cmpxchg
      default: begin
        alu_result = lhs - rhs;
        alu_flags  = flags_pkg::sub_flags(lhs, rhs);
      end
    endcase
  end

  // extra bit catches the last bit shifted out
  assign shamt   = uop.b[SHAMT_WIDTH-1:0];
  assign shl_ext = {1'b0, uop.a} << shamt;
  assign shr_ext = {uop.a, 1'b0} >> shamt;

  always_comb begin
    if (uop.opcode == uop_pkg::OP_SHL) begin
      shift_result = shl_ext[`EX_DATA_WIDTH-1:0];
      sh_flags     = flags_pkg::shift_flags(shift_result, shl_ext[`EX_DATA_WIDTH]);
    end else begin
      shift_result = shr_ext[`EX_DATA_WIDTH:1];
      sh_flags     = flags_pkg::shift_flags(shift_result, shr_ext[0]);
    end
  end

  assign cmp_equal = alu_flags[flags_pkg::ZF_BIT];

  always_comb begin
    wb_next          = '0;
    wb_next.dest_a   = uop.dst;
    wb_next.dest_b   = uop.src;
    wb_next.result_a = alu_result;
    wb_next.result_b = uop.a;
    wb_next.flags    = alu_flags;
    case (uop.opcode)
      uop_pkg::OP_LDI: begin
        wb_next.result_a = uop.a;
        wb_next.ld_a     = 1'b1;
      end
      uop_pkg::OP_MOV: begin
        wb_next.result_a = uop.b;
        wb_next.ld_a     = 1'b1;
      end
      uop_pkg::OP_ADD, uop_pkg::OP_SUB, uop_pkg::OP_AND, uop_pkg::OP_OR,
      uop_pkg::OP_XOR: begin
        wb_next.ld_a     = 1'b1;
        wb_next.ld_flags = 1'b1;
      end
      uop_pkg::OP_CMP: begin
        wb_next.ld_flags = 1'b1;
      end
      uop_pkg::OP_SHL, uop_pkg::OP_SHR: begin
        wb_next.result_a = shift_result;
        wb_next.flags    = sh_flags;
        wb_next.ld_a     = 1'b1;
        // zero count keeps old flags
        wb_next.ld_flags = (shamt != '0);
      end
      uop_pkg::OP_XCHG: begin
        wb_next.result_a = uop.b;
        wb_next.ld_a     = 1'b1;
        wb_next.ld_b     = 1'b1;
      end
      uop_pkg::OP_CMPXCHG: begin
        // equal: src to dst, else dst to reg0
        wb_next.result_a = uop.b;
        wb_next.ld_a     = cmp_equal;
        wb_next.dest_b   = '0;
        wb_next.ld_b     = !cmp_equal;
        wb_next.ld_flags = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= ex.valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (ex.valid) begin
      wb.payload <= wb_next;
    end
  end

  a_wb_valid_known: assert property (@(posedge CLK) !rst |-> !$isunknown(wb.valid));

  a_ld_b_exchange: assert property (@(posedge CLK) disable iff (rst)
    wb.valid && wb.payload.ld_b |->
      $past(uop.opcode) inside {uop_pkg::OP_XCHG, uop_pkg::OP_CMPXCHG});

endmodule

`default_nettype wire

// File: design/result_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_params.svh"

module result_stage (
  input  logic                          CLK,
  input  logic                          rst,
  stage_if.consumer                     wb,
  output logic                          we_a,
  output logic [`EX_REG_ADDR_WIDTH-1:0] wr_addr_a,
  output logic [`EX_DATA_WIDTH-1:0]     wr_data_a,
  output logic                          we_b,
  output logic [`EX_REG_ADDR_WIDTH-1:0] wr_addr_b,
  output logic [`EX_DATA_WIDTH-1:0]     wr_data_b,
  output logic                          retire_valid,
  output logic                          retire_we_a,
  output logic [`EX_REG_ADDR_WIDTH-1:0] retire_dest_a,
  output logic [`EX_DATA_WIDTH-1:0]     retire_value_a,
  output logic                          retire_we_b,
  output logic [`EX_REG_ADDR_WIDTH-1:0] retire_dest_b,
  output logic [`EX_DATA_WIDTH-1:0]     retire_value_b,
  output flags_pkg::eflags_t            retire_flags
);

  flags_pkg::eflags_t flags_q;

  // register file writes
  assign we_a      = wb.valid && wb.payload.ld_a;
  assign wr_addr_a = wb.payload.dest_a;
  assign wr_data_a = wb.payload.result_a;
  assign we_b      = wb.valid && wb.payload.ld_b;
  assign wr_addr_b = wb.payload.dest_b;
  assign wr_data_b = wb.payload.result_b;

  always_ff @(posedge CLK) begin
    if (rst) begin
      flags_q <= '0;
    end else if (wb.valid && wb.payload.ld_flags) begin
      flags_q <= wb.payload.flags;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      retire_valid <= 1'b0;
      retire_we_a  <= 1'b0;
      retire_we_b  <= 1'b0;
    end else begin
      retire_valid <= wb.valid;
      retire_we_a  <= we_a;
      retire_we_b  <= we_b;
    end
  end

  always_ff @(posedge CLK) begin
    if (wb.valid) begin
      retire_dest_a  <= wr_addr_a;
      retire_value_a <= wr_data_a;
      retire_dest_b  <= wr_addr_b;
      retire_value_b <= wr_data_b;
    end
  end

  // flags updated on the same edge as the retirement
  assign retire_flags = flags_q;

  a_retire_follows: assert property (@(posedge CLK) disable iff (rst)
    1'b1 |=> retire_valid == $past(wb.valid));

endmodule

`default_nettype wire

// File: design/ex_core_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_params.svh"

module ex_core_top (
  input  logic                          CLK,
  input  logic                          rst,
  input  logic                          instr_valid,
  input  logic [`EX_INSTR_WIDTH-1:0]    instr,
  output logic                          retire_valid,
  output logic                          retire_we_a,
  output logic [`EX_REG_ADDR_WIDTH-1:0] retire_dest_a,
  output logic [`EX_DATA_WIDTH-1:0]     retire_value_a,
  output logic                          retire_we_b,
  output logic [`EX_REG_ADDR_WIDTH-1:0] retire_dest_b,
  output logic [`EX_DATA_WIDTH-1:0]     retire_value_b,
  output logic [31:0]                   retire_flags
);

  logic [`EX_REG_ADDR_WIDTH-1:0] rd_addr_a;
  logic [`EX_REG_ADDR_WIDTH-1:0] rd_addr_b;
  logic [`EX_DATA_WIDTH-1:0]     rd_data_a;
  logic [`EX_DATA_WIDTH-1:0]     rd_data_b;
  logic [`EX_DATA_WIDTH-1:0]     rd_data_acc;
  logic                          we_a;
  logic [`EX_REG_ADDR_WIDTH-1:0] wr_addr_a;
  logic [`EX_DATA_WIDTH-1:0]     wr_data_a;
  logic                          we_b;
  logic [`EX_REG_ADDR_WIDTH-1:0] wr_addr_b;
  logic [`EX_DATA_WIDTH-1:0]     wr_data_b;

  stage_if #(.payload_t(uop_pkg::ex_payload_t)) ex_bus ();
  stage_if #(.payload_t(uop_pkg::wb_payload_t)) wb_bus ();

  reg_file u_reg_file (
    .CLK         (CLK),
    .rst         (rst),
    .rd_addr_a   (rd_addr_a),
    .rd_addr_b   (rd_addr_b),
    .rd_data_a   (rd_data_a),
    .rd_data_b   (rd_data_b),
    .rd_data_acc (rd_data_acc),
    .we_a        (we_a),
    .wr_addr_a   (wr_addr_a),
    .wr_data_a   (wr_data_a),
    .we_b        (we_b),
    .wr_addr_b   (wr_addr_b),
    .wr_data_b   (wr_data_b)
  );

  decode_stage u_decode (
    .CLK         (CLK),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rd_addr_a   (rd_addr_a),
    .rd_addr_b   (rd_addr_b),
    .rd_data_a   (rd_data_a),
    .rd_data_b   (rd_data_b),
    .rd_data_acc (rd_data_acc),
    .ex          (ex_bus.producer)
  );

  execute_stage u_execute (
    .CLK (CLK),
    .rst (rst),
    .ex  (ex_bus.consumer),
    .wb  (wb_bus.producer)
  );

  result_stage u_result (
    .CLK            (CLK),
    .rst            (rst),
    .wb             (wb_bus.consumer),
    .we_a           (we_a),
    .wr_addr_a      (wr_addr_a),
    .wr_data_a      (wr_data_a),
    .we_b           (we_b),
    .wr_addr_b      (wr_addr_b),
    .wr_data_b      (wr_data_b),
    .retire_valid   (retire_valid),
    .retire_we_a    (retire_we_a),
    .retire_dest_a  (retire_dest_a),
    .retire_value_a (retire_value_a),
    .retire_we_b    (retire_we_b),
    .retire_dest_b  (retire_dest_b),
    .retire_value_b (retire_value_b),
    .retire_flags   (retire_flags)
  );

endmodule

`default_nettype wire

// File: tb/clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS = 10
) (
  output logic CLK
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2.0) CLK = ~CLK;
  end

endmodule

`default_nettype wire

// File: tb/ex_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_params.svh"

module ex_core_tb;

  localparam int RESET_CYCLES     = 10;
  localparam int CYCLES_PER_INSTR = 20;
  localparam int SLACK_CYCLES     = 50;

  // one expected retirement
  typedef struct packed {
    logic                          we_a;
    logic [`EX_REG_ADDR_WIDTH-1:0] dest_a;
    logic [`EX_DATA_WIDTH-1:0]     value_a;
    logic                          we_b;
    logic [`EX_REG_ADDR_WIDTH-1:0] dest_b;
    logic [`EX_DATA_WIDTH-1:0]     value_b;
    flags_pkg::eflags_t            flags;
    int                            cycle;
  } retire_t;

  logic                          CLK;
  logic                          rst;
  logic                          instr_valid;
  logic [`EX_INSTR_WIDTH-1:0]    instr;
  logic                          retire_valid;
  logic                          retire_we_a;
  logic [`EX_REG_ADDR_WIDTH-1:0] retire_dest_a;
  logic [`EX_DATA_WIDTH-1:0]     retire_value_a;
  logic                          retire_we_b;
  logic [`EX_REG_ADDR_WIDTH-1:0] retire_dest_b;
  logic [`EX_DATA_WIDTH-1:0]     retire_value_b;
  logic [31:0]                   retire_flags;

  logic [`EX_DATA_WIDTH-1:0] model_regs [`EX_REG_COUNT];
  flags_pkg::eflags_t        model_flags;
  retire_t                   exp_q [$];
  integer                    seed;
  int                        cycle = 0;
  int                        issued = 0;
  int                        error_count = 0;
  logic                      last_we_a;
  logic                      last_we_b;
  flags_pkg::eflags_t        last_flags;

  clk_gen #(.PERIOD_NS(10)) u_clk (.CLK(CLK));

  ex_core_top dut (
    .CLK            (CLK),
    .rst            (rst),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .retire_valid   (retire_valid),
    .retire_we_a    (retire_we_a),
    .retire_dest_a  (retire_dest_a),
    .retire_value_a (retire_value_a),
    .retire_we_b    (retire_we_b),
    .retire_dest_b  (retire_dest_b),
    .retire_value_b (retire_value_b),
    .retire_flags   (retire_flags)
  );

  always @(posedge CLK) begin
    cycle <= cycle + 1;
  end

  task automatic report_failure(input string what);
    error_count++;
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [`EX_DATA_WIDTH-1:0] got,
                             input logic [`EX_DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_dest(input string name, input logic [`EX_REG_ADDR_WIDTH-1:0] got,
                            input logic [`EX_REG_ADDR_WIDTH-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flags(input string name, input flags_pkg::eflags_t got,
                             input flags_pkg::eflags_t exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  function automatic flags_pkg::eflags_t zero_sign(input logic [`EX_DATA_WIDTH-1:0] r);
    flags_pkg::eflags_t f;
    f = '0;
    f[flags_pkg::ZF_BIT] = (r == '0);
    f[flags_pkg::SF_BIT] = r[`EX_DATA_WIDTH-1];
    return f;
  endfunction

  // carry from unsigned compare, overflow when the signed result does not fit
  function automatic flags_pkg::eflags_t arith_flags(input logic [`EX_DATA_WIDTH-1:0] a,
                                                     input logic [`EX_DATA_WIDTH-1:0] b,
                                                     input logic is_sub);
    logic [`EX_DATA_WIDTH-1:0] r;
    longint                    wide;
    flags_pkg::eflags_t        f;
    if (is_sub) begin
      r = a - b;
      wide = longint'($signed(a)) - longint'($signed(b));
    end else begin
      r = a + b;
      wide = longint'($signed(a)) + longint'($signed(b));
    end
    f = zero_sign(r);
    f[flags_pkg::CF_BIT] = is_sub ? (a < b) : (r < a);
    f[flags_pkg::OF_BIT] = (wide != longint'($signed(r)));
    return f;
  endfunction

  task automatic model_step(input logic [3:0] op, input logic [2:0] d, input logic [2:0] s,
                            input logic [5:0] imm, input int retire_cycle);
    logic [`EX_DATA_WIDTH-1:0] a;
    logic [`EX_DATA_WIDTH-1:0] b;
    logic [`EX_DATA_WIDTH-1:0] acc;
    int                        cnt;
    retire_t                   e;
    a = model_regs[d];
    b = model_regs[s];
    acc = model_regs[0];
    cnt = int'(b[4:0]);
    e = '0;
    e.dest_a = d;
    e.dest_b = s;
    e.value_a = a;
    case (op)
      uop_pkg::OP_LDI: begin
        e.we_a = 1'b1;
        e.value_a = {26'b0, imm};
      end
      uop_pkg::OP_MOV: begin
        e.we_a = 1'b1;
        e.value_a = b;
      end
      uop_pkg::OP_ADD: begin
        e.we_a = 1'b1;
        e.value_a = a + b;
        model_flags = arith_flags(a, b, 1'b0);
      end
      uop_pkg::OP_SUB: begin
        e.we_a = 1'b1;
        e.value_a = a - b;
        model_flags = arith_flags(a, b, 1'b1);
      end
      uop_pkg::OP_AND, uop_pkg::OP_OR, uop_pkg::OP_XOR: begin
        e.we_a = 1'b1;
        if (op == uop_pkg::OP_AND) begin
          e.value_a = a & b;
        end else if (op == uop_pkg::OP_OR) begin
          e.value_a = a | b;
        end else begin
          e.value_a = a ^ b;
        end
        model_flags = zero_sign(e.value_a);
      end
      uop_pkg::OP_CMP: begin
        model_flags = arith_flags(a, b, 1'b1);
      end
      uop_pkg::OP_SHL, uop_pkg::OP_SHR: begin
        e.we_a = 1'b1;
        e.value_a = (op == uop_pkg::OP_SHL) ? (a << cnt) : (a >> cnt);
        if (cnt != 0) begin
          model_flags = zero_sign(e.value_a);
          model_flags[flags_pkg::CF_BIT] = (op == uop_pkg::OP_SHL) ? a[32 - cnt] : a[cnt - 1];
        end
      end
      uop_pkg::OP_XCHG: begin
        e.we_a = 1'b1;
        e.value_a = b;
        e.we_b = 1'b1;
        e.value_b = a;
      end
      default: begin
        // cmpxchg against reg0
        model_flags = arith_flags(acc, a, 1'b1);
        if (acc == a) begin
          e.we_a = 1'b1;
          e.value_a = b;
        end else begin
          e.we_b = 1'b1;
          e.dest_b = '0;
          e.value_b = a;
        end
      end
    endcase
    if (e.we_a) begin
      model_regs[e.dest_a] = e.value_a;
    end
    if (e.we_b) begin
      model_regs[e.dest_b] = e.value_b;
    end
    e.flags = model_flags;
    e.cycle = retire_cycle;
    exp_q.push_back(e);
  endtask

  task automatic issue(input logic [3:0] op, input logic [2:0] d, input logic [2:0] s,
                       input logic [5:0] imm);
    @(posedge CLK);
    instr_valid <= 1'b1;
    instr <= {op, d, s, imm};
    issued++;
    // cycle still holds the pre-edge count, retirement shows four edges later
    if (op <= uop_pkg::OP_CMPXCHG) begin
      model_step(op, d, s, imm, cycle + 4);
    end
  endtask

  task automatic idle();
    @(posedge CLK);
    instr_valid <= 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(negedge CLK);
    end
  endtask

  task automatic exec(input logic [3:0] op, input logic [2:0] d, input logic [2:0] s,
                      input logic [5:0] imm);
    issue(op, d, s, imm);
    idle();
    drain();
  endtask

  // r6 and r7 are scratch
  task automatic load_random(input logic [2:0] r);
    logic [31:0] rv;
    rv = $random(seed);
    exec(uop_pkg::OP_LDI, r, 3'd0, rv[5:0]);
    exec(uop_pkg::OP_LDI, 3'd7, 3'd0, rv[11:6]);
    exec(uop_pkg::OP_SHL, r, 3'd7, 6'd0);
    exec(uop_pkg::OP_LDI, 3'd6, 3'd0, rv[17:12]);
    exec(uop_pkg::OP_XOR, r, 3'd6, 6'd0);
    exec(uop_pkg::OP_LDI, 3'd7, 3'd0, rv[23:18]);
    exec(uop_pkg::OP_SHL, r, 3'd7, 6'd0);
    exec(uop_pkg::OP_XOR, r, 3'd6, 6'd0);
  endtask

  always @(negedge CLK) begin : retire_monitor
    retire_t e;
    if (!rst && retire_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        report_failure("a retirement appeared with no legal instruction in flight");
      end else begin
        e = exp_q.pop_front();
        if (cycle != e.cycle) begin
          report_failure($sformatf("retired in cycle %0d but expected in cycle %0d",
                                   cycle, e.cycle));
        end
        check_bit("retire_we_a", retire_we_a, e.we_a);
        check_bit("retire_we_b", retire_we_b, e.we_b);
        if (e.we_a) begin
          check_dest("retire_dest_a", retire_dest_a, e.dest_a);
          check_value("retire_value_a", retire_value_a, e.value_a);
        end
        if (e.we_b) begin
          check_dest("retire_dest_b", retire_dest_b, e.dest_b);
          check_value("retire_value_b", retire_value_b, e.value_b);
        end
        check_flags("retire_flags", retire_flags, e.flags);
        last_we_a = retire_we_a;
        last_we_b = retire_we_b;
        last_flags = retire_flags;
      end
    end
  end

  // limit grows with every issued instruction
  always @(posedge CLK) begin
    if (cycle > RESET_CYCLES + SLACK_CYCLES + CYCLES_PER_INSTR * issued) begin
      report_failure($sformatf("run timed out after %0d cycles with %0d instructions issued",
                               cycle, issued));
    end
  end

  task automatic test_reset_and_load();
    repeat (5) @(negedge CLK);
    check_bit("retire_valid", retire_valid, 1'b0);
    for (int i = 0; i < `EX_REG_COUNT; i++) begin
      exec(uop_pkg::OP_LDI, 3'(i), 3'd0, 6'(i * 9 + 5));
    end
    exec(uop_pkg::OP_MOV, 3'd5, 3'd2, 6'd0);
    exec(uop_pkg::OP_MOV, 3'd0, 3'd7, 6'd0);
  endtask

  task automatic test_alu();
    logic [3:0] ops [6];
    ops = '{uop_pkg::OP_ADD, uop_pkg::OP_SUB, uop_pkg::OP_AND,
            uop_pkg::OP_OR, uop_pkg::OP_XOR, uop_pkg::OP_CMP};
    for (int iter = 0; iter < 3; iter++) begin
      load_random(3'd1);
      load_random(3'd2);
      for (int k = 0; k < 6; k++) begin
        exec(uop_pkg::OP_MOV, 3'd3, 3'd1, 6'd0);
        exec(ops[k], 3'd3, 3'd2, 6'd0);
      end
    end
    // equal operands for a set zero flag
    exec(uop_pkg::OP_CMP, 3'd1, 3'd1, 6'd0);
  endtask

  task automatic test_shift();
    logic [31:0]        rv;
    flags_pkg::eflags_t flags_before;
    for (int iter = 0; iter < 4; iter++) begin
      load_random(3'd1);
      rv = $random(seed);
      exec(uop_pkg::OP_LDI, 3'd4, 3'd0, rv[5:0]);
      exec(uop_pkg::OP_MOV, 3'd2, 3'd1, 6'd0);
      exec(uop_pkg::OP_SHL, 3'd2, 3'd4, 6'd0);
      exec(uop_pkg::OP_SHR, 3'd1, 3'd4, 6'd0);
    end
    // count field sees only bits 4..0, so 32 means no shift
    exec(uop_pkg::OP_CMP, 3'd1, 3'd2, 6'd0);
    flags_before = model_flags;
    exec(uop_pkg::OP_LDI, 3'd4, 3'd0, 6'd32);
    exec(uop_pkg::OP_SHL, 3'd1, 3'd4, 6'd0);
    check_flags("retire_flags", last_flags, flags_before);
    exec(uop_pkg::OP_SHR, 3'd2, 3'd4, 6'd0);
    check_flags("retire_flags", last_flags, flags_before);
  endtask

  task automatic test_xchg();
    load_random(3'd1);
    load_random(3'd2);
    // reversed order, so a subtract of dst and src by xchg would show
    exec(uop_pkg::OP_CMP, 3'd2, 3'd1, 6'd0);
    exec(uop_pkg::OP_XCHG, 3'd1, 3'd2, 6'd0);
    check_bit("retire_we_a", last_we_a, 1'b1);
    check_bit("retire_we_b", last_we_b, 1'b1);
    exec(uop_pkg::OP_MOV, 3'd3, 3'd1, 6'd0);
    exec(uop_pkg::OP_MOV, 3'd4, 3'd2, 6'd0);
  endtask

  task automatic test_cmpxchg();
    exec(uop_pkg::OP_LDI, 3'd0, 3'd0, 6'd21);
    exec(uop_pkg::OP_LDI, 3'd3, 3'd0, 6'd21);
    exec(uop_pkg::OP_LDI, 3'd4, 3'd0, 6'd9);
    exec(uop_pkg::OP_CMPXCHG, 3'd3, 3'd4, 6'd0);
    check_bit("retire_flags.zf", last_flags[flags_pkg::ZF_BIT], 1'b1);
    exec(uop_pkg::OP_MOV, 3'd5, 3'd3, 6'd0);
    exec(uop_pkg::OP_LDI, 3'd0, 3'd0, 6'd5);
    exec(uop_pkg::OP_LDI, 3'd3, 3'd0, 6'd17);
    exec(uop_pkg::OP_CMPXCHG, 3'd3, 3'd4, 6'd0);
    check_bit("retire_flags.zf", last_flags[flags_pkg::ZF_BIT], 1'b0);
    exec(uop_pkg::OP_MOV, 3'd5, 3'd0, 6'd0);
  endtask

  task automatic test_back_to_back();
    issue(uop_pkg::OP_LDI, 3'd1, 3'd0, 6'h11);
    issue(uop_pkg::OP_LDI, 3'd2, 3'd0, 6'h22);
    issue(4'hc, 3'd3, 3'd3, 6'h3f);
    issue(uop_pkg::OP_XOR, 3'd5, 3'd5, 6'd0);
    issue(4'hf, 3'd1, 3'd2, 6'd0);
    issue(uop_pkg::OP_MOV, 3'd4, 3'd6, 6'd0);
    idle();
    drain();
    // illegal codes must stay silent
    repeat (8) @(negedge CLK);
  endtask

  initial begin
    seed = 32'hf335_41de;
    rst = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    model_flags = '0;
    last_we_a = 1'b0;
    last_we_b = 1'b0;
    last_flags = '0;
    for (int i = 0; i < `EX_REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge CLK);
    rst <= 1'b0;
    test_reset_and_load();
    test_alu();
    test_shift();
    test_xchg();
    test_cmpxchg();
    test_back_to_back();
    repeat (5) @(negedge CLK);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/flags_pkg.sv
design/uop_pkg.sv
design/stage_if.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/ex_core_top.sv
tb/clk_gen.sv
tb/ex_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and judge the run from its log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module ex_core_tb -Mdir "$BUILD_DIR" -o ex_core_sim \
  || { echo "verilator build failed"; exit 1; }

"./$BUILD_DIR/ex_core_sim" > "$LOG" 2>&1
cat "$LOG"

grep -q "Finished with errors" "$LOG" && { echo "simulation failed, see $LOG"; exit 1; }
grep -q "Finished with no errors" "$LOG" || { echo "no result line in $LOG"; exit 1; }
echo "simulation passed"
